// File: verification/icache_stim.txt
# vaddr ptag uncached expected_instr expected_miss
# hex fields, one fetch request per line, issued back to back
000 1 0 efff1000 1
004 1 0 effb1004 0
008 1 0 eff71008 1
010 1 0 efef1010 1
014 1 0 efeb1014 0
000 1 0 efff1000 0
020 2 1 dfdf2020 1
024 2 0 dfdb2024 1
020 2 1 dfdf2020 1
008 3 0 cff73008 1
00c 1 0 eff3100c 1
00c 3 0 cff3300c 1
030 4 0 bfcf4030 1
034 4 0 bfcb4034 0
038 4 0 bfc74038 1
010 1 0 efef1010 0
040 5 1 afbf5040 1
03c 4 0 bfc3403c 0
7f8 f 0 0807f7f8 1
7fc f 0 0803f7fc 0

// File: flist.f
+incdir+verification
design/icache_geom_pkg.sv
design/icache_mem_pkg.sv
design/replay_fifo.sv
design/icache_arrays.sv
design/icache_pipe.sv
design/miss_engine.sv
design/icache_fetch_top.sv
verification/tb_icache_fetch.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_icache_fetch
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))
HEADERS   := $(wildcard verification/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_checks.svh
task automatic check_instr(input string name, input instr_t exp_v, input instr_t act_v);
  if (act_v !== exp_v)
    fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp_v, act_v));
endtask

task automatic check_count(input string name, input int exp_v, input int act_v);
  if (act_v != exp_v)
    fail_run($sformatf("[ERROR] %s expected %0d actual %0d", name, exp_v, act_v));
endtask

task automatic check_addr(input string name, input mem_addr_t exp_v,
                          input mem_addr_t act_v);
  if (act_v !== exp_v)
    fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp_v, act_v));
endtask

// Upper LCG bits carry the useful randomness
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// File: verification/tb_icache_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module tb_icache_fetch;

  import icache_geom_pkg::*;
  import icache_mem_pkg::*;

  logic      clk_i;
  logic      arst_n_i;
  logic      fetch_v_i;
  vaddr_t    fetch_vaddr_i;
  ptag_t     fetch_ptag_i;
  logic      fetch_uncached_i;
  logic      fetch_ready_o;
  instr_t    fetch_data_o;
  logic      fetch_data_v_o;
  mem_addr_t mem_cmd_addr_o;
  logic      mem_cmd_v_o;
  logic      mem_cmd_ready_i;
  block_t    mem_resp_data_i;
  logic      mem_resp_v_i;
  logic      mem_resp_yumi_o;

  // Requests in file order and what they should produce
  vaddr_t    req_vaddr [$];
  ptag_t     req_ptag [$];
  logic      req_unc [$];
  instr_t    exp_instr [$];
  mem_addr_t exp_cmd_q [$];
  int        exp_miss_total = 0;

  int          resp_count = 0;
  int          cmd_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic        full_seen = 1'b0;
  logic [31:0] lcg_state;

  icache_fetch_top u_icache_fetch_top (.*);

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  `include "tb_checks.svh"

  // Word at p holds its inverse above p
  function automatic instr_t mem_word(input paddr_t p);
    return {~p, p};
  endfunction

  function automatic block_t mem_block(input mem_addr_t a);
    return {mem_word(a + 16'd4), mem_word(a)};
  endfunction

  task automatic load_stim();
    int          fd;
    int          n;
    int          lnum;
    string       line;
    logic [31:0] f_vaddr, f_ptag, f_unc, f_instr, f_miss;
    logic [15:0] shadow_valid;
    ctag_t       shadow_tag [16];
    paddr_t      p;
    logic        miss;
    fd = $fopen("verification/icache_stim.txt", "r");
    if (fd == 0)
      fail_run("cannot open verification/icache_stim.txt");
    shadow_valid = '0;
    lnum = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      lnum++;
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h", f_vaddr, f_ptag, f_unc, f_instr, f_miss);
        if (n != 5)
          fail_run($sformatf("stimulus line %0d has the wrong number of fields", lnum));
        p = {f_ptag[3:0], f_vaddr[11:0]};
        // Direct-mapped shadow where uncached requests never fill
        miss = f_unc[0] | ~(shadow_valid[p[6:3]] & (shadow_tag[p[6:3]] == p[15:7]));
        if (!f_unc[0]) begin
          shadow_valid[p[6:3]] = 1'b1;
          shadow_tag[p[6:3]]   = p[15:7];
        end
        if (f_instr != mem_word({p[15:2], 2'b00}))
          fail_run($sformatf("stimulus line %0d disagrees with the memory rule", lnum));
        if (f_miss[0] != miss)
          fail_run($sformatf("stimulus line %0d miss flag disagrees with the cache", lnum));
        if (miss) begin
          exp_cmd_q.push_back({p[15:3], 3'b000});
          exp_miss_total++;
        end
        req_vaddr.push_back(f_vaddr[11:0]);
        req_ptag.push_back(f_ptag[3:0]);
        req_unc.push_back(f_unc[0]);
        exp_instr.push_back(f_instr);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin : main
    int i;
    arst_n_i         = 1'b0;
    fetch_v_i        = 1'b0;
    fetch_vaddr_i    = '0;
    fetch_ptag_i     = '0;
    fetch_uncached_i = 1'b0;
    mem_cmd_ready_i  = 1'b0;
    mem_resp_v_i     = 1'b0;
    mem_resp_data_i  = '0;
    load_stim();
    cycle_limit = exp_instr.size() * 40 + 100;
    repeat (3) @(posedge clk_i);
    #1 arst_n_i = 1'b1;
    @(posedge clk_i);
    #1;
    // Back-to-back pushes held until the queue accepts
    for (i = 0; i < req_vaddr.size(); i++) begin
      fetch_v_i        = 1'b1;
      fetch_vaddr_i    = req_vaddr[i];
      fetch_ptag_i     = req_ptag[i];
      fetch_uncached_i = req_unc[i];
      do @(negedge clk_i); while (!fetch_ready_o);
      @(posedge clk_i);
      #1;
    end
    fetch_v_i = 1'b0;
    while (resp_count < req_vaddr.size())
      @(negedge clk_i);
    // Let any stray command show up
    repeat (10) @(negedge clk_i);
    check_count("mem_cmd_count", exp_miss_total, cmd_count);
    if (!full_seen) begin
      fail_run("fetch_ready_o never dropped while the queue was full");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  // In-order scoreboard
  initial begin : scoreboard
    @(posedge arst_n_i);
    forever begin
      @(negedge clk_i);
      if (!fetch_ready_o)
        full_seen = 1'b1;
      if (fetch_data_v_o) begin
        if (resp_count >= exp_instr.size())
          fail_run("fetch data returned with no request left to answer");
        check_instr($sformatf("fetch_%0d", resp_count), exp_instr[resp_count], fetch_data_o);
        resp_count++;
      end
    end
  end

  // Block memory with random command stall and response delay
  initial begin : memory_model
    mem_addr_t addr;
    int        stall;
    int        delay;
    lcg_state = 32'h2f5acd48;
    @(posedge arst_n_i);
    forever begin
      @(negedge clk_i);
      if (mem_cmd_v_o) begin
        lcg_state = lcg_next(lcg_state);
        stall     = int'(lcg_state[31:30]);
        lcg_state = lcg_next(lcg_state);
        delay     = int'(lcg_state[31:30]);
        repeat (stall) @(negedge clk_i);
        @(posedge clk_i);
        #1 mem_cmd_ready_i = 1'b1;
        @(negedge clk_i);
        addr = mem_cmd_addr_o;
        cmd_count++;
        if (exp_cmd_q.size() == 0)
          fail_run("memory command issued with no miss expected");
        check_addr($sformatf("mem_cmd_%0d", cmd_count), exp_cmd_q.pop_front(), addr);
        @(posedge clk_i);
        #1 mem_cmd_ready_i = 1'b0;
        repeat (delay) begin
          @(posedge clk_i);
          #1;
        end
        mem_resp_v_i    = 1'b1;
        mem_resp_data_i = mem_block(addr);
        do @(negedge clk_i); while (!mem_resp_yumi_o);
        @(posedge clk_i);
        #1 mem_resp_v_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    @(posedge arst_n_i);
    forever begin
      @(posedge clk_i);
      cycle_count++;
      if (cycle_count > cycle_limit)
        fail_run($sformatf("run did not finish within %0d cycles", cycle_limit));
    end
  end

endmodule

`default_nettype wire

// File: design/icache_fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_fetch_top
  (input  logic                      clk_i
   , input  logic                    arst_n_i

   , input  logic                    fetch_v_i
   , input  icache_geom_pkg::vaddr_t fetch_vaddr_i
   , input  icache_geom_pkg::ptag_t  fetch_ptag_i
   , input  logic                    fetch_uncached_i
   , output logic                    fetch_ready_o

   , output icache_geom_pkg::instr_t fetch_data_o
   , output logic                    fetch_data_v_o

   , output icache_mem_pkg::mem_addr_t mem_cmd_addr_o
   , output logic                    mem_cmd_v_o
   , input  logic                    mem_cmd_ready_i

   , input  icache_geom_pkg::block_t mem_resp_data_i
   , input  logic                    mem_resp_v_i
   , output logic                    mem_resp_yumi_o
   );

  import icache_geom_pkg::*;
  import icache_mem_pkg::*;

  fetch_entry_t issue_entry;
  logic         issue_v, issue_yumi;

  index_t rd_index;
  logic   rd_valid;
  ctag_t  rd_tag;
  block_t rd_data;

  logic   miss_v, miss_uncached, miss_busy;
  paddr_t miss_paddr;

  logic   fill_v;
  index_t fill_index;
  ctag_t  fill_tag;
  block_t fill_data;

  logic   unc_v;
  instr_t unc_data;

  replay_fifo u_replay_fifo
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.push_v_i(fetch_v_i)
     ,.push_entry_i({fetch_uncached_i, fetch_ptag_i, fetch_vaddr_i})
     ,.push_ready_o(fetch_ready_o)
     ,.issue_v_o(issue_v)
     ,.issue_entry_o(issue_entry)
     ,.issue_yumi_i(issue_yumi)
     ,.retire_i(fetch_data_v_o)
     );

  icache_pipe u_icache_pipe
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.issue_v_i(issue_v)
     ,.issue_entry_i(issue_entry)
     ,.issue_yumi_o(issue_yumi)
     ,.rd_index_o(rd_index)
     ,.rd_valid_i(rd_valid)
     ,.rd_tag_i(rd_tag)
     ,.rd_data_i(rd_data)
     ,.fetch_data_o(fetch_data_o)
     ,.fetch_data_v_o(fetch_data_v_o)
     ,.miss_v_o(miss_v)
     ,.miss_paddr_o(miss_paddr)
     ,.miss_uncached_o(miss_uncached)
     ,.miss_busy_i(miss_busy)
     ,.unc_v_i(unc_v)
     ,.unc_data_i(unc_data)
     );

  icache_arrays u_icache_arrays
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.rd_index_i(rd_index)
     ,.rd_valid_o(rd_valid)
     ,.rd_tag_o(rd_tag)
     ,.rd_data_o(rd_data)
     ,.fill_v_i(fill_v)
     ,.fill_index_i(fill_index)
     ,.fill_tag_i(fill_tag)
     ,.fill_data_i(fill_data)
     );

  miss_engine u_miss_engine
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.miss_v_i(miss_v)
     ,.miss_paddr_i(miss_paddr)
     ,.miss_uncached_i(miss_uncached)
     ,.busy_o(miss_busy)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_addr_o(mem_cmd_addr_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_data_i(mem_resp_data_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     ,.fill_v_o(fill_v)
     ,.fill_index_o(fill_index)
     ,.fill_tag_o(fill_tag)
     ,.fill_data_o(fill_data)
     ,.unc_v_o(unc_v)
     ,.unc_data_o(unc_data)
     );

endmodule

`default_nettype wire

// File: design/miss_engine.sv
`timescale 1ns/10ps
`default_nettype none

module miss_engine
  (input  logic                      clk_i
   , input  logic                    arst_n_i

   , input  logic                    miss_v_i
   , input  icache_geom_pkg::paddr_t miss_paddr_i
   , input  logic                    miss_uncached_i
   , output logic                    busy_o

   , output logic                    mem_cmd_v_o
   , output icache_mem_pkg::mem_addr_t mem_cmd_addr_o
   , input  logic                    mem_cmd_ready_i

   , input  logic                    mem_resp_v_i
   , input  icache_geom_pkg::block_t mem_resp_data_i
   , output logic                    mem_resp_yumi_o

   , output logic                    fill_v_o
   , output icache_geom_pkg::index_t fill_index_o
   , output icache_geom_pkg::ctag_t  fill_tag_o
   , output icache_geom_pkg::block_t fill_data_o

   , output logic                    unc_v_o
   , output icache_geom_pkg::instr_t unc_data_o
   );

  import icache_geom_pkg::*;
  import icache_mem_pkg::*;

  miss_state_e state_r, state_n;

  paddr_t miss_paddr_r;
  logic   miss_uncached_r;
  block_t resp_buf_r;

  assign busy_o          = (state_r != e_ready);
  assign mem_cmd_v_o     = (state_r == e_send_cmd);
  assign mem_resp_yumi_o = (state_r == e_wait_resp) & mem_resp_v_i;

  assign mem_cmd_addr_o = {miss_paddr_r[paddr_width_lp-1:block_offset_width_lp],
                           {block_offset_width_lp{1'b0}}};

  // Response buffer drains into the arrays or the uncached buffer
  assign fill_v_o     = (state_r == e_fill) & ~miss_uncached_r;
  assign fill_index_o = miss_paddr_r[block_offset_width_lp +: index_width_lp];
  assign fill_tag_o   = miss_paddr_r[paddr_width_lp-1 -: ctag_width_lp];
  assign fill_data_o  = resp_buf_r;

  assign unc_v_o    = (state_r == e_fill) & miss_uncached_r;
  assign unc_data_o = miss_paddr_r[block_offset_width_lp-1]
                      ? resp_buf_r[block_width_lp-1 -: instr_width_lp]
                      : resp_buf_r[instr_width_lp-1:0];

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_ready:     if (miss_v_i) state_n = e_send_cmd;
      e_send_cmd:  if (mem_cmd_ready_i) state_n = e_wait_resp;
      e_wait_resp: if (mem_resp_v_i) state_n = e_fill;
      e_fill:      state_n = e_ready;
      default:     state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i)
      state_r <= e_ready;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == e_ready) && miss_v_i) begin
      miss_paddr_r    <= miss_paddr_i;
      miss_uncached_r <= miss_uncached_i;
    end
    if (mem_resp_yumi_o)
      resp_buf_r <= mem_resp_data_i;
  end

  // Command held steady under back-pressure
  a_cmd_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_cmd_v_o && !mem_cmd_ready_i |=> mem_cmd_v_o && $stable(mem_cmd_addr_o));

endmodule

`default_nettype wire

// File: design/icache_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module icache_pipe
  (input  logic                         clk_i
   , input  logic                       arst_n_i

   , input  logic                       issue_v_i
   , input  icache_mem_pkg::fetch_entry_t issue_entry_i
   , output logic                       issue_yumi_o

   , output icache_geom_pkg::index_t    rd_index_o
   , input  logic                       rd_valid_i
   , input  icache_geom_pkg::ctag_t     rd_tag_i
   , input  icache_geom_pkg::block_t    rd_data_i

   , output icache_geom_pkg::instr_t    fetch_data_o
   , output logic                       fetch_data_v_o

   , output logic                       miss_v_o
   , output icache_geom_pkg::paddr_t    miss_paddr_o
   , output logic                       miss_uncached_o
   , input  logic                       miss_busy_i

   , input  logic                       unc_v_i
   , input  icache_geom_pkg::instr_t    unc_data_i
   );

  import icache_geom_pkg::*;
  import icache_mem_pkg::*;

  // Tag lookup stage
  logic         tl_v_r;
  fetch_entry_t tl_entry_r;

  // Tag verify stage
  logic         tv_v_r;
  fetch_entry_t tv_entry_r;
  paddr_t       tv_paddr;
  logic         tv_uncached;
  ctag_t        tv_ctag;
  instr_t       tv_cached_word;
  logic         cached_hit;
  logic         unc_hit;
  logic         tv_hit;
  logic         tv_miss;
  logic         pipe_ready;

  // Uncached buffer
  logic         unc_buf_v_r;
  instr_t       unc_buf_data_r;
  paddr_t       unc_buf_paddr_r;
  paddr_t       miss_paddr_r;

  assign pipe_ready   = ~miss_busy_i & ~tv_miss;
  assign issue_yumi_o = issue_v_i & pipe_ready;

  assign rd_index_o = tl_entry_r[block_offset_width_lp +: index_width_lp];

  assign tv_paddr    = tv_entry_r[paddr_width_lp-1:0];
  assign tv_uncached = tv_entry_r[paddr_width_lp];
  assign tv_ctag     = tv_paddr[paddr_width_lp-1 -: ctag_width_lp];

  // Bit 2 picks the upper word of the block
  assign tv_cached_word = tv_paddr[block_offset_width_lp-1]
                          ? rd_data_i[block_width_lp-1 -: instr_width_lp]
                          : rd_data_i[instr_width_lp-1:0];

  assign cached_hit = rd_valid_i & (rd_tag_i == tv_ctag);
  assign unc_hit    = unc_buf_v_r & (unc_buf_paddr_r == tv_paddr);
  assign tv_hit     = tv_uncached ? unc_hit : cached_hit;
  assign tv_miss    = tv_v_r & ~tv_hit;

  assign fetch_data_v_o = tv_v_r & tv_hit;
  assign fetch_data_o   = tv_uncached ? unc_buf_data_r : tv_cached_word;

  assign miss_v_o        = tv_miss;
  assign miss_paddr_o    = tv_paddr;
  assign miss_uncached_o = tv_uncached;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tl_v_r      <= 1'b0;
      tv_v_r      <= 1'b0;
      unc_buf_v_r <= 1'b0;
    end else begin
      tl_v_r <= issue_yumi_o;
      // Miss squashes the younger request
      tv_v_r <= tl_v_r & ~tv_miss;
      if (unc_v_i)
        unc_buf_v_r <= 1'b1;
      else if (fetch_data_v_o & tv_uncached)
        unc_buf_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    tl_entry_r <= issue_entry_i;
    tv_entry_r <= tl_entry_r;
    if (tv_miss)
      miss_paddr_r <= tv_paddr;
    if (unc_v_i) begin
      unc_buf_data_r  <= unc_data_i;
      unc_buf_paddr_r <= miss_paddr_r;
    end
  end

  a_no_data_while_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(fetch_data_v_o && miss_busy_i));

  // Engine takes every miss on the next cycle
  a_miss_taken: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    miss_v_o |=> miss_busy_i);

endmodule

`default_nettype wire

// File: design/icache_arrays.sv
`timescale 1ns/10ps
`default_nettype none

module icache_arrays
  (input  logic                    clk_i
   , input  logic                  arst_n_i

   , input  icache_geom_pkg::index_t rd_index_i
   , output logic                  rd_valid_o
   , output icache_geom_pkg::ctag_t  rd_tag_o
   , output icache_geom_pkg::block_t rd_data_o

   , input  logic                  fill_v_i
   , input  icache_geom_pkg::index_t fill_index_i
   , input  icache_geom_pkg::ctag_t  fill_tag_i
   , input  icache_geom_pkg::block_t fill_data_i
   );

  import icache_geom_pkg::*;

  logic [sets_lp-1:0] valid_r;
  ctag_t  tag_mem  [sets_lp];
  block_t data_mem [sets_lp];

  // Valid bits
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_r    <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      if (fill_v_i)
        valid_r[fill_index_i] <= 1'b1;
      rd_valid_o <= valid_r[rd_index_i];
    end
  end

  // Tag and data, synchronous read
  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_mem[fill_index_i]  <= fill_tag_i;
      data_mem[fill_index_i] <= fill_data_i;
    end
    rd_tag_o  <= tag_mem[rd_index_i];
    rd_data_o <= data_mem[rd_index_i];
  end

endmodule

`default_nettype wire

// File: design/replay_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module replay_fifo
  (input  logic                         clk_i
   , input  logic                       arst_n_i

   , input  logic                       push_v_i
   , input  icache_mem_pkg::fetch_entry_t push_entry_i
   , output logic                       push_ready_o

   , output logic                       issue_v_o
   , output icache_mem_pkg::fetch_entry_t issue_entry_o
   , input  logic                       issue_yumi_i

   , input  logic                       retire_i
   );

  import icache_mem_pkg::*;

  // One wrap bit above the slot index
  typedef logic [$clog2(replay_depth_lp):0] ptr_t;

  fetch_entry_t mem_r [replay_depth_lp];

  ptr_t wptr_r, iptr_r, rptr_r;
  ptr_t occupancy;
  logic full;
  logic push_fire;
  logic yumi_r, yumi_rr;
  logic rollback;

  assign occupancy    = wptr_r - rptr_r;
  assign full         = (occupancy == ptr_t'(replay_depth_lp));
  assign push_ready_o = ~full;
  assign push_fire    = push_v_i & push_ready_o;

  assign issue_v_o     = (iptr_r != wptr_r);
  assign issue_entry_o = mem_r[iptr_r[$clog2(replay_depth_lp)-1:0]];

  // Issued two cycles ago and not retired now
  assign rollback = yumi_rr & ~retire_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_r  <= '0;
      iptr_r  <= '0;
      rptr_r  <= '0;
      yumi_r  <= 1'b0;
      yumi_rr <= 1'b0;
    end else begin
      yumi_r  <= issue_yumi_i;
      yumi_rr <= yumi_r;
      if (push_fire)
        wptr_r <= wptr_r + 1'b1;
      if (retire_i)
        rptr_r <= rptr_r + 1'b1;
      if (rollback)
        iptr_r <= rptr_r;
      else if (issue_yumi_i)
        iptr_r <= iptr_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_fire)
      mem_r[wptr_r[$clog2(replay_depth_lp)-1:0]] <= push_entry_i;
  end

  // Never holds more than the ring
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    occupancy <= ptr_t'(replay_depth_lp));

  // Issue pointer stays between retire and write
  a_issue_window: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ptr_t'(iptr_r - rptr_r) <= occupancy);

endmodule

`default_nettype wire

// File: design/icache_mem_pkg.sv
`default_nettype none

package icache_mem_pkg;

  // Replay queue depth
  localparam int replay_depth_lp = 8;

  // {uncached, ptag, vaddr}
  typedef logic [icache_geom_pkg::paddr_width_lp:0] fetch_entry_t;

  // Block-aligned physical address
  typedef logic [icache_geom_pkg::paddr_width_lp-1:0] mem_addr_t;

  typedef enum logic [1:0] {
    e_ready     = 2'd0,
    e_send_cmd  = 2'd1,
    e_wait_resp = 2'd2,
    e_fill      = 2'd3
  } miss_state_e;

endpackage

`default_nettype wire

// File: design/icache_geom_pkg.sv
`default_nettype none

package icache_geom_pkg;

  // Fetch address space
  localparam int vaddr_width_lp = 12;
  localparam int ptag_width_lp  = 4;
  localparam int paddr_width_lp = ptag_width_lp + vaddr_width_lp;

  // Payload widths
  localparam int instr_width_lp = 32;
  localparam int block_width_lp = 64;

  // Direct-mapped geometry, 8-byte blocks
  localparam int sets_lp               = 16;
  localparam int index_width_lp        = 4;
  localparam int block_offset_width_lp = 3;
  localparam int ctag_width_lp         = paddr_width_lp - index_width_lp
                                         - block_offset_width_lp;

  typedef logic [vaddr_width_lp-1:0] vaddr_t;
  typedef logic [ptag_width_lp-1:0]  ptag_t;

  // ptag on top of the page offset
  typedef logic [paddr_width_lp-1:0] paddr_t;

  typedef logic [index_width_lp-1:0] index_t;
  typedef logic [ctag_width_lp-1:0]  ctag_t;
  typedef logic [instr_width_lp-1:0] instr_t;
  typedef logic [block_width_lp-1:0] block_t;

endpackage

`default_nettype wire
